/* sim.f */
+incdir+source
source/rx_front_pkg.sv
source/cfo_nco.sv
source/cmplx_mixer.sv
source/cic_decim.sv
source/rx_front.sv
test/tb_rx_front.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the rx_front testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal -j 0 \
    --top-module tb_rx_front \
    -Mdir obj_dir -o sim_bin \
    -f sim.f

./obj_dir/sim_bin > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi

echo "simulation finished, see sim.log"

/* test/tb_rx_front.sv */
`timescale 1ns/1ns
`include "rx_front_params.svh"

module tb_rx_front;

    localparam int N_DC     = 40;
    localparam int N_CFO    = 60;
    localparam int N_REL    = 80;
    localparam int N_SAT    = 200;
    localparam int N_RAND   = 2000;
    localparam int DRAIN    = 12;
    localparam int LUT_SIZE = 1 << `RX_LUT_AW;
    localparam int N_STAGE  = `RX_CIC_N;

    // worst case with every random gap at its longest
    localparam int MAX_CYCLES = 4 + 9 + N_DC + 5 + 1 + N_CFO + N_REL + 1 + 4 * N_SAT
                                + 2 * N_RAND + DRAIN;

    logic                  clk_i;
    logic                  reset_ni;
    rx_front_pkg::sample_t in_re_i;
    rx_front_pkg::sample_t in_im_i;
    logic                  in_valid_i;
    rx_front_pkg::phase_t  cfo_inc_i;
    logic                  cfo_valid_i;
    rx_front_pkg::sample_t out_re_o;
    rx_front_pkg::sample_t out_im_o;
    logic                  out_valid_o;

    integer seed = 36;
    int     errors = 0;
    int     checks = 0;
    int     cycle_cnt = 0;   // rising edges seen so far
    int     last_re = 0;     // latest DUT output pair
    int     last_im = 0;

    // reference model state
    rx_front_pkg::trig_t    cos_tab [LUT_SIZE];
    rx_front_pkg::trig_t    sin_tab [LUT_SIZE];
    rx_front_pkg::phase_t   m_inc = '0;
    rx_front_pkg::phase_t   m_phase = '0;
    rx_front_pkg::cic_acc_t integ [2][N_STAGE];
    rx_front_pkg::cic_acc_t comb_dly [2][N_STAGE];
    bit                     m_keep = 1'b0;   // second sample after reset is kept
    rx_front_pkg::sample_t  model_out [2];

    int exp_re_q [$];
    int exp_im_q [$];
    int exp_cyc_q [$];

    rx_front DUT (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_re_i     (in_re_i),
        .in_im_i     (in_im_i),
        .in_valid_i  (in_valid_i),
        .cfo_inc_i   (cfo_inc_i),
        .cfo_valid_i (cfo_valid_i),
        .out_re_o    (out_re_o),
        .out_im_o    (out_im_o),
        .out_valid_o (out_valid_o)
    );

    always #50 clk_i = ~clk_i;

    task automatic check_value(input string what, input logic signed [31:0] got,
                               input logic signed [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic int round_nearest(input real x);
        if (x >= 0.0) begin
            return $rtoi(x + 0.5);
        end
        return -$rtoi(-x + 0.5);
    endfunction

    // Q1.15 product back to a rail with half-up rounding and clipping
    function automatic rx_front_pkg::sample_t round_and_clip(input longint acc);
        longint v;
        v = (acc + 64'sd16384) >>> 15;
        if (v > 32767) begin
            v = 32767;
        end else if (v < -32768) begin
            v = -32768;
        end
        return rx_front_pkg::sample_t'(v);
    endfunction

    // advances the whole chain by one driven cycle and returns 1 when an output is due
    function automatic bit model_step(input bit iv, input rx_front_pkg::sample_t re,
                                      input rx_front_pkg::sample_t im, input bit cv,
                                      input rx_front_pkg::phase_t inc);
        logic [`RX_LUT_AW-1:0]  idx;
        longint                 c;
        longint                 s;
        rx_front_pkg::sample_t  mixed [2];
        rx_front_pkg::cic_acc_t stage;
        rx_front_pkg::cic_acc_t diff;
        rx_front_pkg::cic_acc_t scaled;
        bit                     kept;
        kept = 1'b0;
        if (iv) begin
            idx = m_phase[`RX_PHASE_DW-1 -: `RX_LUT_AW];   // phase before the advance
            c = longint'(cos_tab[idx]);
            s = longint'(sin_tab[idx]);
            mixed[0] = round_and_clip(longint'(re) * c - longint'(im) * s);
            mixed[1] = round_and_clip(longint'(re) * s + longint'(im) * c);
            m_phase = m_phase + m_inc;
            for (int r = 0; r < 2; r++) begin
                stage = rx_front_pkg::cic_acc_t'(mixed[r]);
                for (int k = 0; k < N_STAGE; k++) begin
                    integ[r][k] = integ[r][k] + stage;
                    stage = integ[r][k];
                end
                if (m_keep) begin
                    for (int k = 0; k < N_STAGE; k++) begin
                        diff = stage - comb_dly[r][k];
                        comb_dly[r][k] = stage;
                        stage = diff;
                    end
                    scaled = stage >>> `RX_CIC_GROWTH;
                    model_out[r] = scaled[`RX_SAMPLE_DW-1:0];
                end
            end
            kept = m_keep;
            m_keep = !m_keep;
        end
        if (cv) begin
            m_inc = m_inc - inc;   // relative update after this cycle's advance
        end
        return kept;
    endfunction

    task automatic drive_cycle(input bit iv, input rx_front_pkg::sample_t re,
                               input rx_front_pkg::sample_t im, input bit cv,
                               input rx_front_pkg::phase_t inc);
        @(negedge clk_i);
        in_valid_i  = iv;
        in_re_i     = re;
        in_im_i     = im;
        cfo_valid_i = cv;
        cfo_inc_i   = inc;
        if (model_step(iv, re, im, cv, inc)) begin
            exp_re_q.push_back(int'(model_out[0]));
            exp_im_q.push_back(int'(model_out[1]));
            exp_cyc_q.push_back(cycle_cnt + 5);   // sampled on the edge after this one
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, '0, '0, 1'b0, '0);
    endtask

    // compare every output strobe against the oldest prediction
    always @(posedge clk_i) begin
        if (out_valid_o === 1'b1) begin
            last_re = out_re_o;
            last_im = out_im_o;
            if (exp_re_q.size() == 0) begin
                errors++;
                $display("out_valid_o went high at %0t ns with no output expected", $time);
            end else begin
                check_value("out_re_o", out_re_o, exp_re_q.pop_front());
                check_value("out_im_o", out_im_o, exp_im_q.pop_front());
                check_value("output strobe cycle", cycle_cnt, exp_cyc_q.pop_front());
            end
        end
        cycle_cnt = cycle_cnt + 1;
    end

    initial begin
        #((MAX_CYCLES + 20) * 100);
        $display("watchdog expired at %0t ns before the tests finished", $time);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        bit                    cv;
        bit                    gap_cv;
        int                    gap;
        rx_front_pkg::sample_t re;
        rx_front_pkg::sample_t im;
        rx_front_pkg::phase_t  inc;
        rx_front_pkg::phase_t  gap_inc;

        clk_i       = 1'b0;
        reset_ni    = 1'b0;
        in_re_i     = '0;
        in_im_i     = '0;
        in_valid_i  = 1'b0;
        cfo_inc_i   = '0;
        cfo_valid_i = 1'b0;

        for (int k = 0; k < LUT_SIZE; k++) begin
            cos_tab[k] = rx_front_pkg::trig_t'(round_nearest(
                32767.0 * $cos(2.0 * 3.141592653589793 * k / 256.0)));
            sin_tab[k] = rx_front_pkg::trig_t'(round_nearest(
                32767.0 * $sin(2.0 * 3.141592653589793 * k / 256.0)));
        end
        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k < N_STAGE; k++) begin
                integ[r][k]    = '0;
                comb_dly[r][k] = '0;
            end
        end

        repeat (2) begin
            @(negedge clk_i);
            check_value("out_valid_o in reset", out_valid_o, 0);
        end
        reset_ni = 1'b1;

        // a lone first strobe must not produce an output
        drive_cycle(1'b1, 16'sd1000, 16'sd2000, 1'b0, '0);
        repeat (8) begin
            idle_cycles(1);
            check_value("out_valid_o after first strobe", out_valid_o, 0);
        end

        // DC at phase 0
        repeat (N_DC) drive_cycle(1'b1, 16'sd12000, -16'sd5000, 1'b0, '0);
        while (exp_re_q.size() != 0) begin
            idle_cycles(1);
        end
        // 32767/32768 of either rail rounds back to the input
        check_value("settled DC real", last_re, 12000);
        check_value("settled DC imag", last_im, -5000);

        // single update, constant input rotates
        drive_cycle(1'b0, '0, '0, 1'b1, -20'sd9000);
        repeat (N_CFO) drive_cycle(1'b1, 16'sd20000, 16'sd0, 1'b0, '0);

        // updates land on strobe and idle cycles alike
        for (int i = 0; i < N_REL; i++) begin
            cv  = (i % 7) == 3;
            inc = rx_front_pkg::phase_t'(((i % 5) - 2) * 1500);
            drive_cycle((i % 4) != 3, 16'sd15000, -16'sd9000, cv, inc);
        end

        // full scale with a fast sweep hits mixer saturation
        drive_cycle(1'b0, '0, '0, 1'b1, -20'sd65536);
        for (int i = 0; i < N_SAT; i++) begin
            gap = $random(seed) & 3;
            idle_cycles(gap);
            re = ($random(seed) & 1) ? 16'sd32767 : -16'sd32768;
            im = ($random(seed) & 1) ? 16'sd32767 : -16'sd32768;
            drive_cycle(1'b1, re, im, 1'b0, '0);
        end

        for (int i = 0; i < N_RAND; i++) begin
            if (($random(seed) & 3) == 0) begin
                gap_cv  = ($random(seed) & 15) == 0;
                gap_inc = rx_front_pkg::phase_t'($random(seed) % 4096);
                drive_cycle(1'b0, '0, '0, gap_cv, gap_inc);
            end
            re  = rx_front_pkg::sample_t'($random(seed));
            im  = rx_front_pkg::sample_t'($random(seed));
            cv  = ($random(seed) & 31) == 0;
            inc = rx_front_pkg::phase_t'($random(seed) % 4096);
            drive_cycle(1'b1, re, im, cv, inc);
        end

        idle_cycles(DRAIN);
        if (exp_re_q.size() != 0) begin
            errors++;
            $display("%0d expected outputs never appeared on out_valid_o", exp_re_q.size());
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* source/rx_front.sv */
`timescale 1ns/1ns

module rx_front (
    input  logic                  clk_i,
    input  logic                  reset_ni,

    input  rx_front_pkg::sample_t in_re_i,
    input  rx_front_pkg::sample_t in_im_i,
    input  logic                  in_valid_i,

    input  rx_front_pkg::phase_t  cfo_inc_i,
    input  logic                  cfo_valid_i,

    output rx_front_pkg::sample_t out_re_o,
    output rx_front_pkg::sample_t out_im_o,
    output logic                  out_valid_o
);

    // NCO to mixer
    rx_front_pkg::sample_t nco_re;
    rx_front_pkg::sample_t nco_im;
    rx_front_pkg::trig_t   nco_cos;
    rx_front_pkg::trig_t   nco_sin;
    logic                  nco_valid;

    // mixer to CIC rails
    rx_front_pkg::sample_t mix_re;
    rx_front_pkg::sample_t mix_im;
    logic                  mix_valid;

    cfo_nco nco_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_re_i     (in_re_i),
        .in_im_i     (in_im_i),
        .in_valid_i  (in_valid_i),
        .cfo_inc_i   (cfo_inc_i),
        .cfo_valid_i (cfo_valid_i),
        .re_o        (nco_re),
        .im_o        (nco_im),
        .cos_o       (nco_cos),
        .sin_o       (nco_sin),
        .valid_o     (nco_valid)
    );

    cmplx_mixer mixer_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .re_i     (nco_re),
        .im_i     (nco_im),
        .cos_i    (nco_cos),
        .sin_i    (nco_sin),
        .valid_i  (nco_valid),
        .re_o     (mix_re),
        .im_o     (mix_im),
        .valid_o  (mix_valid)
    );

    cic_decim cic_re (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .data_i   (mix_re),
        .valid_i  (mix_valid),
        .data_o   (out_re_o),
        .valid_o  (out_valid_o)
    );

    // same strobe as the real rail, its valid is redundant
    cic_decim cic_im (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .data_i   (mix_im),
        .valid_i  (mix_valid),
        .data_o   (out_im_o),
        .valid_o  ()
    );

endmodule

/* source/cic_decim.sv */
`timescale 1ns/1ns
`include "rx_front_params.svh"

module cic_decim (
    input  logic                  clk_i,
    input  logic                  reset_ni,

    input  rx_front_pkg::sample_t data_i,
    input  logic                  valid_i,

    output rx_front_pkg::sample_t data_o,
    output logic                  valid_o
);

    localparam int N    = `RX_CIC_N;
    localparam int R    = `RX_CIC_R;
    localparam int PH_W = (R > 1) ? $clog2(R) : 1;

    logic [PH_W-1:0] phase_q;   // position inside the decimation period
    logic            keep;

    // integrators run on every strobe, combs only on kept samples
    assign keep = valid_i && (phase_q == PH_W'(R - 1));

    for (genvar g = 0; g < N; g++) begin : g_stage
        rx_front_pkg::cic_acc_t int_q;
        rx_front_pkg::cic_acc_t int_d;
        rx_front_pkg::cic_acc_t comb_in;
        rx_front_pkg::cic_acc_t comb_d;
        rx_front_pkg::cic_acc_t dly_q;   // differential delay of one

        if (g == 0) begin : g_first
            assign int_d   = int_q + rx_front_pkg::cic_acc_t'(data_i);
            assign comb_in = g_stage[N-1].int_d;   // last integrator, this sample included
        end else begin : g_next
            assign int_d   = int_q + g_stage[g-1].int_d;
            assign comb_in = g_stage[g-1].comb_d;
        end

        assign comb_d = comb_in - dly_q;   // wraps, growth is covered

        always_ff @(posedge clk_i) begin
            if (!reset_ni) begin
                int_q <= '0;
                dly_q <= '0;
            end else begin
                if (valid_i) begin
                    int_q <= int_d;
                end
                if (keep) begin
                    dly_q <= comb_in;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            phase_q <= '0;
            valid_o <= 1'b0;
        end else begin
            if (valid_i) begin
                phase_q <= keep ? '0 : phase_q + 1'b1;
            end
            valid_o <= keep;
        end
    end

    // drop the gain of R^N
    always_ff @(posedge clk_i) begin
        if (keep) begin
            data_o <= rx_front_pkg::sample_t'(g_stage[N-1].comb_d >>> `RX_CIC_GROWTH);
        end
    end

    // decimated output never strobes twice in a row
    a_cic_spacing: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        valid_o |=> !valid_o
    );

endmodule

/* source/cmplx_mixer.sv */
`timescale 1ns/1ns
`include "rx_front_params.svh"

module cmplx_mixer (
    input  logic                  clk_i,
    input  logic                  reset_ni,

    input  rx_front_pkg::sample_t re_i,
    input  rx_front_pkg::sample_t im_i,
    input  rx_front_pkg::trig_t   cos_i,
    input  rx_front_pkg::trig_t   sin_i,
    input  logic                  valid_i,

    output rx_front_pkg::sample_t re_o,
    output rx_front_pkg::sample_t im_o,
    output logic                  valid_o
);

    localparam int PROD_W = `RX_SAMPLE_DW + `RX_TRIG_DW;
    localparam int SHIFT  = `RX_TRIG_DW - 1;   // back from Q1.15

    typedef logic signed [PROD_W-1:0] prod_t;
    typedef logic signed [PROD_W:0]   sum_t;

    localparam sum_t ROUND   = sum_t'(1 << (SHIFT - 1));
    localparam sum_t SAT_MAX = sum_t'((1 << (`RX_SAMPLE_DW - 1)) - 1);
    localparam sum_t SAT_MIN = -SAT_MAX - sum_t'(1);

    prod_t rc_q;   // re * cos
    prod_t is_q;   // im * sin
    prod_t rs_q;   // re * sin
    prod_t ic_q;   // im * cos
    logic  valid_q;

    // round half up, then clip to the rail width
    function automatic rx_front_pkg::sample_t round_sat(input sum_t acc);
        sum_t shifted;
        shifted = (acc + ROUND) >>> SHIFT;
        if (shifted > SAT_MAX) begin
            return rx_front_pkg::sample_t'(SAT_MAX);
        end else if (shifted < SAT_MIN) begin
            return rx_front_pkg::sample_t'(SAT_MIN);
        end
        return rx_front_pkg::sample_t'(shifted);
    endfunction

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_q <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            valid_q <= valid_i;
            valid_o <= valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            rc_q <= re_i * cos_i;
            is_q <= im_i * sin_i;
            rs_q <= re_i * sin_i;
            ic_q <= im_i * cos_i;
        end
        if (valid_q) begin
            re_o <= round_sat(sum_t'(rc_q) - sum_t'(is_q));
            im_o <= round_sat(sum_t'(rs_q) + sum_t'(ic_q));
        end
    end

    a_mix_latency: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        ($past(reset_ni) && $past(reset_ni, 2)) |-> (valid_o == $past(valid_i, 2))
    );

endmodule

/* source/cfo_nco.sv */
`timescale 1ns/1ns
`include "rx_front_params.svh"

module cfo_nco (
    input  logic                  clk_i,
    input  logic                  reset_ni,

    input  rx_front_pkg::sample_t in_re_i,
    input  rx_front_pkg::sample_t in_im_i,
    input  logic                  in_valid_i,

    input  rx_front_pkg::phase_t  cfo_inc_i,   // relative to the last update
    input  logic                  cfo_valid_i,

    output rx_front_pkg::sample_t re_o,
    output rx_front_pkg::sample_t im_o,
    output rx_front_pkg::trig_t   cos_o,
    output rx_front_pkg::trig_t   sin_o,
    output logic                  valid_o
);

    localparam int  LUT_SIZE   = 1 << `RX_LUT_AW;
    localparam real TWO_PI     = 6.283185307179586;
    localparam real TRIG_SCALE = (2.0 ** (`RX_TRIG_DW - 1)) - 1.0;

    rx_front_pkg::trig_t cos_lut [LUT_SIZE];
    rx_front_pkg::trig_t sin_lut [LUT_SIZE];

    rx_front_pkg::phase_t  inc_q;        // running increment
    rx_front_pkg::phase_t  phase_q;      // phase for the next sample
    rx_front_pkg::phase_t  rot_phase_q;  // phase of the sample in stage 1
    rx_front_pkg::sample_t re_q;
    rx_front_pkg::sample_t im_q;
    logic                  valid_q;
    logic [`RX_LUT_AW-1:0] lut_idx;

    // one full turn over the table rounded to nearest
    initial begin
        for (int k = 0; k < LUT_SIZE; k++) begin
            cos_lut[k] = rx_front_pkg::trig_t'(int'(TRIG_SCALE * $cos(TWO_PI * k / LUT_SIZE)));
            sin_lut[k] = rx_front_pkg::trig_t'(int'(TRIG_SCALE * $sin(TWO_PI * k / LUT_SIZE)));
        end
    end

    assign lut_idx = rot_phase_q[`RX_PHASE_DW-1 -: `RX_LUT_AW];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            inc_q   <= '0;
            phase_q <= '0;
            valid_q <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            if (cfo_valid_i) begin
                inc_q <= inc_q - cfo_inc_i;  // estimates are relative
            end
            if (in_valid_i) begin
                phase_q <= phase_q + inc_q;  // old increment on a coinciding update
            end
            valid_q <= in_valid_i;
            valid_o <= valid_q;
        end
    end

    // stage 1 takes the phase before its advance
    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            rot_phase_q <= phase_q;
            re_q        <= in_re_i;
            im_q        <= in_im_i;
        end
    end

    // stage 2 reads the table and the sample follows along
    always_ff @(posedge clk_i) begin
        if (valid_q) begin
            cos_o <= cos_lut[lut_idx];
            sin_o <= sin_lut[lut_idx];
            re_o  <= re_q;
            im_o  <= im_q;
        end
    end

    // rotation and sample leave together two cycles after the strobe
    a_nco_latency: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        ($past(reset_ni) && $past(reset_ni, 2)) |-> (valid_o == $past(in_valid_i, 2))
    );

    a_nco_align: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        valid_o |-> (re_o == $past(in_re_i, 2)) && (im_o == $past(in_im_i, 2))
            && (cos_o == cos_lut[$past(phase_q[`RX_PHASE_DW-1 -: `RX_LUT_AW], 2)])
            && (sin_o == sin_lut[$past(phase_q[`RX_PHASE_DW-1 -: `RX_LUT_AW], 2)])
    );

endmodule

/* source/rx_front_pkg.sv */
`include "rx_front_params.svh"

package rx_front_pkg;

    // signed I or Q sample
    typedef logic signed [`RX_SAMPLE_DW-1:0] sample_t;

    // phase or increment, wraps modulo 2^RX_PHASE_DW
    // signed so that increments read as +/- frequency
    typedef logic signed [`RX_PHASE_DW-1:0] phase_t;

    // cosine or sine value, Q1.15
    typedef logic signed [`RX_TRIG_DW-1:0] trig_t;

    // CIC integrator and comb word
    typedef logic signed [`RX_SAMPLE_DW+`RX_CIC_GROWTH-1:0] cic_acc_t;

endpackage

/* source/rx_front_params.svh */
`ifndef RX_FRONT_PARAMS_SVH
`define RX_FRONT_PARAMS_SVH

// one I or Q rail
`define RX_SAMPLE_DW 16

// phase accumulator and CFO increment
`define RX_PHASE_DW 20

// phase MSBs used as table address
`define RX_LUT_AW 8

// cos and sin in Q1.15
`define RX_TRIG_DW 16

// CIC decimator, order and rate
`define RX_CIC_N 3
`define RX_CIC_R 2
`define RX_CIC_GROWTH 3   // N * log2(R * M) with M = 1

`endif
